// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_jpeg_dq

out=$(./obj_dir/Vtb_jpeg_dq)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
else
  exit 1
fi

// File: filelist.f
jpeg_dq_pkg.sv
dqt_wr_if.sv
jpeg_dq_ctrl.sv
jpeg_dq_counter.sv
jpeg_qt_store.sv
jpeg_dequant.sv
jpeg_dq_top.sv
tb_jpeg_dq.sv

// File: tb_jpeg_dq.sv
`timescale 1ns/10ps

module tb_jpeg_dq
  import jpeg_dq_pkg::*;
();

  localparam int clk_half = 4;
  localparam int done_timeout = 100;
  localparam logic [31:0] seed = 32'hb636_19ae;

  logic                     clk;
  logic                     rst;
  logic                     i_word_valid;
  logic        [word_w-1:0] i_word;
  logic                     i_dqt_start;
  logic                     i_blk_start;
  qt_id_t                   i_blk_qt;
  logic                     i_coef_valid;
  logic signed [coef_w-1:0] i_coef;
  logic                     o_busy;
  logic                     o_dqt_done;
  logic                     o_blk_done;
  idx_t                     i_rd_addr;
  logic signed [prod_w-1:0] o_rd_data;

  // model tables in zigzag order, the coefficients and the expected 8x8 result
  logic        [qt_w-1:0]   model_qt [n_tables][blk_size];
  logic signed [coef_w-1:0] coefs [blk_size];
  logic signed [prod_w-1:0] expect_buf [blk_size];

  int errors = 0;
  int test_base = 0;
  int tests_run = 0;
  int blk_done_seen = 0;
  int dqt_done_seen = 0;

  jpeg_dq_top DUT (
    .clk          (clk),
    .rst          (rst),
    .i_word_valid (i_word_valid),
    .i_word       (i_word),
    .i_dqt_start  (i_dqt_start),
    .i_blk_start  (i_blk_start),
    .i_blk_qt     (i_blk_qt),
    .i_coef_valid (i_coef_valid),
    .i_coef       (i_coef),
    .o_busy       (o_busy),
    .o_dqt_done   (o_dqt_done),
    .o_blk_done   (o_blk_done),
    .i_rd_addr    (i_rd_addr),
    .o_rd_data    (o_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  always @(negedge clk) begin
    if (o_blk_done) blk_done_seen++;
    if (o_dqt_done) dqt_done_seen++;
  end

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                           input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %0d %s finished with %0d errors", tests_run, name, errors - test_base);
    test_base = errors;
  endtask

  function automatic logic signed [prod_w-1:0] model_prod(input logic [qt_w-1:0] q,
                                                          input logic signed [coef_w-1:0] c);
    logic signed [31:0] p;
    p = $signed(q) * c;
    return p[prod_w-1:0];
  endfunction

  function automatic logic [word_w-1:0] table_word(input int id, input logic pre,
                                                   input int item);
    logic [word_w-1:0] w;
    w = '0;
    if (pre) begin
      for (int j = 0; j < 4; j++) w[word_w-1-16*j -: 16] = model_qt[id][item*4+j];
    end else begin
      for (int j = 0; j < 8; j++) w[word_w-1-8*j -: 8] = model_qt[id][item*8+j][7:0];
    end
    return w;
  endfunction

  task automatic fill_table(input int id, input logic pre);
    for (int k = 0; k < blk_size; k++) begin
      if (pre) model_qt[id][k] = 16'($urandom);
      else model_qt[id][k] = {8'h00, 8'($urandom_range(255, 1))};
    end
  endtask

  task automatic make_coefs(input bit negative);
    for (int k = 0; k < blk_size; k++) begin
      if (negative) coefs[k] = -16'($urandom_range(2047, 1));
      else coefs[k] = 16'($urandom);
    end
  endtask

  task automatic wait_done(input bit blk, output int cycles);
    logic  seen;
    string what;
    cycles = 0;
    seen = 1'b0;
    what = blk ? "block" : "table load";
    while (!seen && cycles < done_timeout) begin
      @(negedge clk);
      cycles++;
      seen = blk ? o_blk_done : o_dqt_done;
      if (!seen) check_val(32'(o_busy), 32'd1, {what, " not busy before done"});
    end
    if (!seen) begin
      errors++;
      $display("the %s never finished: no done pulse within %0d cycles", what, done_timeout);
    end else begin
      check_val(32'(o_busy), 32'd0, {what, " busy after done"});
    end
  endtask

  task automatic load_table(input int id, input logic pre, input int gap_every,
                            output int latency);
    int n_items;
    int seen_start;
    n_items = pre ? 16 : 8;
    seen_start = dqt_done_seen;
    @(posedge clk);
    i_dqt_start <= 1'b1;
    @(posedge clk);
    i_dqt_start <= 1'b0;
    i_word_valid <= 1'b1;
    i_word <= {pre ? 4'h1 : 4'h0, 2'b00, 2'(id), 56'h0};
    for (int i = 0; i < n_items; i++) begin
      if (gap_every > 0 && i % gap_every == 1) begin
        // junk on the bus while valid is low must never be taken
        @(posedge clk);
        i_word_valid <= 1'b0;
        i_word <= {$urandom, $urandom};
      end
      if (i == n_items - 1) begin
        @(negedge clk);
        check_val(32'(o_busy), 32'd1, "busy during table load");
      end
      @(posedge clk);
      if (i == n_items - 1) check_val(32'(dqt_done_seen), 32'(seen_start), "early table done");
      i_word_valid <= 1'b1;
      i_word <= table_word(id, pre, i);
    end
    @(posedge clk);
    i_word_valid <= 1'b0;
    wait_done(1'b0, latency);
    @(negedge clk);
    @(posedge clk);
    check_val(32'(dqt_done_seen), 32'(seen_start + 1), "table done pulse count");
  endtask

  task automatic run_block(input int qt, input bit stray, output int latency);
    int seen_start;
    seen_start = blk_done_seen;
    @(posedge clk);
    i_blk_start <= 1'b1;
    i_blk_qt <= 2'(qt);
    for (int k = 0; k < blk_size; k++) begin
      if (stray && k % 9 == 5) begin
        // a gap carrying a table start and a new table id that must both be ignored
        @(posedge clk);
        i_blk_start <= 1'b0;
        i_coef_valid <= 1'b0;
        i_coef <= 16'($urandom);
        i_blk_qt <= 2'(qt + 1);
        i_dqt_start <= (k == 14);
      end
      if (k == blk_size - 1) begin
        @(negedge clk);
        check_val(32'(o_busy), 32'd1, "busy during block");
      end
      @(posedge clk);
      if (k == blk_size - 1) check_val(32'(blk_done_seen), 32'(seen_start), "early block done");
      i_blk_start <= 1'b0;
      i_dqt_start <= 1'b0;
      i_coef_valid <= 1'b1;
      i_coef <= coefs[k];
    end
    @(posedge clk);
    i_coef_valid <= 1'b0;
    wait_done(1'b1, latency);
    @(negedge clk);
    @(posedge clk);
    check_val(32'(blk_done_seen), 32'(seen_start + 1), "block done pulse count");
  endtask

  task automatic stray_strobes(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      i_coef_valid <= 1'b1;
      i_coef <= 16'($urandom);
      i_word_valid <= 1'b1;
      i_word <= {$urandom, $urandom};
    end
    @(posedge clk);
    i_coef_valid <= 1'b0;
    i_word_valid <= 1'b0;
  endtask

  task automatic build_expect(input int qt);
    for (int k = 0; k < blk_size; k++) begin
      expect_buf[zigzag_to_natural[k]] = model_prod(model_qt[qt][k], coefs[k]);
    end
  endtask

  task automatic read_back(input string name);
    for (int a = 0; a < blk_size; a++) begin
      @(posedge clk);
      i_rd_addr <= idx_t'(a);
      @(posedge clk);
      @(negedge clk);
      check_val(32'(o_rd_data), 32'(expect_buf[a]), $sformatf("%s, address %0d", name, a));
    end
  endtask

  task automatic after_reset();
    @(negedge clk);
    check_val(32'(o_busy), 32'd0, "busy after reset");
    check_val(32'(o_dqt_done), 32'd0, "table done after reset");
    check_val(32'(o_blk_done), 32'd0, "block done after reset");
    for (int a = 0; a < blk_size; a++) expect_buf[a] = '0;
    read_back("buffer after reset");
    end_test("reset state");
  endtask

  task automatic eight_bit_table();
    int lat;
    fill_table(0, 1'b0);
    load_table(0, 1'b0, 0, lat);
    check_val(32'(lat), 32'd1, "8-bit table done latency");
    make_coefs(1'b0);
    run_block(0, 1'b0, lat);
    check_val(32'(lat), 32'd2, "block done latency");
    build_expect(0);
    read_back("8-bit table 0 block");
    end_test("8-bit table");
  endtask

  task automatic signed_16bit_table();
    int lat;
    fill_table(2, 1'b1);
    model_qt[2][0] = 16'h8001;
    model_qt[2][63] = 16'hfff3;
    load_table(2, 1'b1, 0, lat);
    check_val(32'(lat), 32'd1, "16-bit table done latency");
    make_coefs(1'b1);
    run_block(2, 1'b0, lat);
    build_expect(2);
    read_back("16-bit table 2 block");
    end_test("16-bit signed table");
  endtask

  task automatic four_separate_tables();
    int lat;
    for (int id = 0; id < n_tables; id++) begin
      fill_table(id, id[0]);
      load_table(id, id[0], 0, lat);
    end
    make_coefs(1'b0);
    for (int id = 0; id < n_tables; id++) begin
      run_block(id, 1'b0, lat);
      build_expect(id);
      read_back($sformatf("table %0d block", id));
    end
    end_test("four tables");
  endtask

  task automatic gaps_and_strays();
    int lat;
    stray_strobes(3);
    fill_table(1, 1'b1);
    load_table(1, 1'b1, 3, lat);
    check_val(32'(lat), 32'd1, "gapped table done latency");
    stray_strobes(4);
    make_coefs(1'b0);
    run_block(1, 1'b1, lat);
    check_val(32'(lat), 32'd2, "gapped block done latency");
    stray_strobes(5);
    build_expect(1);
    read_back("gapped block");
    end_test("gaps and stray strobes");
  endtask

  initial begin
    void'($urandom(seed));
    rst = 1'b1;
    i_word_valid = 1'b0;
    i_word = '0;
    i_dqt_start = 1'b0;
    i_blk_start = 1'b0;
    i_blk_qt = '0;
    i_coef_valid = 1'b0;
    i_coef = '0;
    i_rd_addr = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    after_reset();
    eight_bit_table();
    signed_16bit_table();
    four_separate_tables();
    gaps_and_strays();
    $display("tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: jpeg_dq_top.sv
`timescale 1ns/10ps

module jpeg_dq_top
  import jpeg_dq_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_word_valid,
  input  logic        [word_w-1:0] i_word,
  input  logic                     i_dqt_start,
  input  logic                     i_blk_start,
  input  qt_id_t                   i_blk_qt,
  input  logic                     i_coef_valid,
  input  logic signed [coef_w-1:0] i_coef,
  output logic                     o_busy,
  output logic                     o_dqt_done,
  output logic                     o_blk_done,
  input  idx_t                     i_rd_addr,
  output logic signed [prod_w-1:0] o_rd_data
);

  logic            cnt_clear;
  logic            cnt_inc;
  idx_t            cnt_limit;
  idx_t            cnt_value;
  logic            cnt_last;
  logic            coef_en;
  qt_id_t          qt_id;
  idx_t            qt_addr;
  logic [qt_w-1:0] qt_data;

  dqt_wr_if u_wr ();

  jpeg_dq_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .i_word_valid (i_word_valid),
    .i_word       (i_word),
    .i_dqt_start  (i_dqt_start),
    .i_blk_start  (i_blk_start),
    .i_blk_qt     (i_blk_qt),
    .i_coef_valid (i_coef_valid),
    .i_cnt_last   (cnt_last),
    .o_cnt_clear  (cnt_clear),
    .o_cnt_inc    (cnt_inc),
    .o_cnt_limit  (cnt_limit),
    .o_busy       (o_busy),
    .o_dqt_done   (o_dqt_done),
    .o_blk_done   (o_blk_done),
    .wr           (u_wr.ctrl),
    .o_coef_en    (coef_en),
    .o_qt_id      (qt_id)
  );

  jpeg_dq_counter u_cnt (
    .clk     (clk),
    .rst     (rst),
    .i_clear (cnt_clear),
    .i_inc   (cnt_inc),
    .i_limit (cnt_limit),
    .o_count (cnt_value),
    .o_last  (cnt_last)
  );

  jpeg_qt_store u_store (
    .clk       (clk),
    .wr        (u_wr.store),
    .i_rd_tbl  (qt_id),
    .i_rd_addr (qt_addr),
    .o_rd_data (qt_data)
  );

  // the running count is the zigzag position of the coefficient
  jpeg_dequant u_dq (
    .clk        (clk),
    .rst        (rst),
    .i_clear    (cnt_clear),
    .i_coef_en  (coef_en),
    .i_coef_idx (cnt_value),
    .i_coef     (i_coef),
    .i_qt       (qt_data),
    .o_qt_addr  (qt_addr),
    .i_rd_addr  (i_rd_addr),
    .o_rd_data  (o_rd_data)
  );

endmodule

// File: jpeg_dequant.sv
`timescale 1ns/10ps

module jpeg_dequant
  import jpeg_dq_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_clear,
  input  logic                     i_coef_en,
  input  idx_t                     i_coef_idx,
  input  logic signed [coef_w-1:0] i_coef,
  input  logic        [qt_w-1:0]   i_qt,
  output idx_t                     o_qt_addr,
  input  idx_t                     i_rd_addr,
  output logic signed [prod_w-1:0] o_rd_data
);

  logic signed [qt_w+coef_w-1:0] prod_full;
  logic signed [prod_w-1:0]      prod_q;
  idx_t                          addr_q;
  logic                          wr_q;
  logic signed [prod_w-1:0]      res_buf [blk_size];

  // the table is indexed by zigzag position, like the coefficients
  assign o_qt_addr = i_coef_idx;

  assign prod_full = $signed(i_qt) * i_coef;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_q <= 1'b0;
    end else begin
      wr_q <= i_coef_en;
    end
  end

  // only the low bits of the product are kept
  always_ff @(posedge clk) begin
    if (i_coef_en) begin
      prod_q <= prod_full[prod_w-1:0];
      addr_q <= zigzag_to_natural[i_coef_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (rst || i_clear) begin
      for (int i = 0; i < blk_size; i++) begin
        res_buf[i] <= '0;
      end
    end else if (wr_q) begin
      res_buf[addr_q] <= prod_q;
    end
  end

  always_ff @(posedge clk) begin
    o_rd_data <= res_buf[i_rd_addr];
  end

endmodule

// File: jpeg_qt_store.sv
`timescale 1ns/10ps

module jpeg_qt_store
  import jpeg_dq_pkg::*;
(
  input  logic            clk,
  dqt_wr_if.store         wr,
  input  qt_id_t          i_rd_tbl,
  input  idx_t            i_rd_addr,
  output logic [qt_w-1:0] o_rd_data
);

  logic [qt_w-1:0] tables [n_tables][blk_size];

  // a word carries eight byte entries or four half-word entries, msb first
  always_ff @(posedge clk) begin
    if (wr.wr_en) begin
      if (!wr.pre) begin
        for (int j = 0; j < 8; j++) begin
          tables[wr.tbl_id][{wr.item[2:0], 3'(j)}] <=
            {8'b0, wr.word[word_w-1-8*j -: 8]};
        end
      end else begin
        for (int j = 0; j < 4; j++) begin
          tables[wr.tbl_id][{wr.item, 2'(j)}] <=
            wr.word[word_w-1-16*j -: 16];
        end
      end
    end
  end

  // entries stay in zigzag order, as they arrive in the segment
  assign o_rd_data = tables[i_rd_tbl][i_rd_addr];

endmodule

// File: jpeg_dq_counter.sv
`timescale 1ns/10ps

module jpeg_dq_counter
  import jpeg_dq_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic i_clear,
  input  logic i_inc,
  input  idx_t i_limit,
  output idx_t o_count,
  output logic o_last
);

  idx_t count;

  assign o_count = count;
  assign o_last  = i_inc && (count == i_limit);

  // wraps back to zero on the final step so the next run starts clean
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (i_clear) begin
      count <= '0;
    end else if (i_inc) begin
      if (o_last) begin
        count <= '0;
      end else begin
        count <= count + 6'd1;
      end
    end
  end

endmodule

// File: jpeg_dq_ctrl.sv
`timescale 1ns/10ps

module jpeg_dq_ctrl
  import jpeg_dq_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              i_word_valid,
  input  logic [word_w-1:0] i_word,
  input  logic              i_dqt_start,
  input  logic              i_blk_start,
  input  qt_id_t            i_blk_qt,
  input  logic              i_coef_valid,
  input  logic              i_cnt_last,
  output logic              o_cnt_clear,
  output logic              o_cnt_inc,
  output idx_t              o_cnt_limit,
  output logic              o_busy,
  output logic              o_dqt_done,
  output logic              o_blk_done,
  dqt_wr_if.ctrl            wr,
  output logic              o_coef_en,
  output qt_id_t            o_qt_id
);

  dq_state_t  state;
  logic       pre;
  qt_id_t     tbl_id;
  qt_id_t     blk_qt;
  logic [3:0] item;
  logic       item_take;
  logic       blk_end;

  assign item_take = (state == st_dqt_item) && i_word_valid;
  assign o_coef_en = (state == st_blk_coef) && i_coef_valid;

  assign o_cnt_clear = (state == st_idle) && (i_dqt_start || i_blk_start);
  assign o_cnt_inc   = item_take || o_coef_en;
  assign o_cnt_limit = (state == st_blk_coef) ? idx_t'(blk_size - 1) :
                       (pre ? 6'd15 : 6'd7);

  // the busy window covers the last product still on its way to the buffer
  assign o_busy  = (state != st_idle) || blk_end;
  assign o_qt_id = blk_qt;

  assign wr.wr_en  = item_take;
  assign wr.tbl_id = tbl_id;
  assign wr.pre    = pre;
  assign wr.item   = item;
  assign wr.word   = i_word;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_idle;
      pre    <= 1'b0;
      tbl_id <= '0;
      blk_qt <= '0;
      item   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (i_dqt_start) begin
            state <= st_dqt_tabl;
          end else if (i_blk_start) begin
            state  <= st_blk_coef;
            blk_qt <= i_blk_qt;
          end
        end
        st_dqt_tabl: begin
          // segment header holds precision in the top nibble, id below it
          if (i_word_valid) begin
            state  <= st_dqt_item;
            pre    <= |i_word[63:60];
            tbl_id <= i_word[57:56];
            item   <= '0;
          end
        end
        st_dqt_item: begin
          if (item_take) begin
            item <= item + 4'd1;
            if (i_cnt_last) state <= st_idle;
          end
        end
        st_blk_coef: begin
          if (o_coef_en && i_cnt_last) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_dqt_done <= 1'b0;
      blk_end    <= 1'b0;
      o_blk_done <= 1'b0;
    end else begin
      o_dqt_done <= item_take && i_cnt_last;
      blk_end    <= o_coef_en && i_cnt_last;
      o_blk_done <= blk_end;
    end
  end

endmodule

// File: dqt_wr_if.sv
`timescale 1ns/10ps

interface dqt_wr_if
  import jpeg_dq_pkg::*;
();

  logic              wr_en;
  qt_id_t            tbl_id;
  // set for 16-bit entries
  logic              pre;
  // word number inside the table segment
  logic [3:0]        item;
  logic [word_w-1:0] word;

  modport ctrl (
    output wr_en,
    output tbl_id,
    output pre,
    output item,
    output word
  );

  modport store (
    input wr_en,
    input tbl_id,
    input pre,
    input item,
    input word
  );

endinterface

// File: jpeg_dq_pkg.sv
package jpeg_dq_pkg;

  localparam int word_w = 64;
  localparam int qt_w = 16;
  localparam int coef_w = 16;
  localparam int prod_w = 24;
  localparam int blk_size = 64;
  localparam int n_tables = 4;

  typedef logic [1:0] qt_id_t;
  typedef logic [5:0] idx_t;

  typedef enum logic [1:0] {
    st_idle,
    st_dqt_tabl,
    st_dqt_item,
    st_blk_coef
  } dq_state_t;

  // row-major position of every zigzag position in an 8x8 block
  localparam idx_t zigzag_to_natural [blk_size] = '{
    6'd0,  6'd1,  6'd8,  6'd16, 6'd9,  6'd2,  6'd3,  6'd10,
    6'd17, 6'd24, 6'd32, 6'd25, 6'd18, 6'd11, 6'd4,  6'd5,
    6'd12, 6'd19, 6'd26, 6'd33, 6'd40, 6'd48, 6'd41, 6'd34,
    6'd27, 6'd20, 6'd13, 6'd6,  6'd7,  6'd14, 6'd21, 6'd28,
    6'd35, 6'd42, 6'd49, 6'd56, 6'd57, 6'd50, 6'd43, 6'd36,
    6'd29, 6'd22, 6'd15, 6'd23, 6'd30, 6'd37, 6'd44, 6'd51,
    6'd58, 6'd59, 6'd52, 6'd45, 6'd38, 6'd31, 6'd39, 6'd46,
    6'd53, 6'd60, 6'd61, 6'd54, 6'd47, 6'd55, 6'd62, 6'd63
  };

endpackage
